// File: Bender.yml
package:
  name: usb_io

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/usb_io_pkg.sv
      - rtl/endpoint_fifo.sv
      - rtl/se0_reset_timer.sv
      - rtl/endpoint_sequencer.sv
      - rtl/shared_bus.sv
      - rtl/usb_io_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/usb_io_assert.sv
      - verification/usb_io_tb.sv

// File: rtl/endpoint_fifo.sv
// Single-clock FIFO of EP_DEPTH entries; first-word output, push when full and pop when empty ignored
`timescale 1ns/10ps
`default_nettype none
`include "usb_io_consts.svh"

module endpoint_fifo #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     flush_i,            // Empties FIFO, e.g. on bus reset
   input  logic     push_i,
   input  logic     pop_i,
   input  payload_t wr_data_i,
   output payload_t rd_data_o,          // Head entry, valid when not empty
   output logic     empty_o,
   output logic     full_o
);

   localparam int AW = $clog2(`EP_DEPTH);
   localparam int CW = $clog2(`EP_DEPTH + 1);
   localparam logic [CW-1:0] DEPTH = CW'(`EP_DEPTH);

   payload_t      mem [`EP_DEPTH];      // Entry storage, no reset
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] count_q;              // Occupancy
   logic          do_push;
   logic          do_pop;

   assign empty_o   = (count_q == '0);
   assign full_o    = (count_q == DEPTH);
   assign do_push   = push_i && !full_o;  // Overflow dropped
   assign do_pop    = pop_i && !empty_o;  // Underflow ignored
   assign rd_data_o = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps, depth is power of two
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;            // Idle or push+pop
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/endpoint_sequencer.sv
// Endpoint FSM; one IN request at a time, drains the latched endpoint up to an entry marked last
`timescale 1ns/10ps
`default_nettype none

module endpoint_sequencer (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  usb_reset_i,
   input  logic                  rx_valid_i,     // Receive stream from SIE
   input  usb_io_pkg::usb_rx_t   rx_data_i,
   output logic                  rx_ready_o,
   input  logic                  in_req_valid_i, // Host IN token
   input  logic                  in_ep_i,        // 0 = EP0, 1 = EP1
   output logic                  in_req_ready_o,
   output logic                  tx_valid_o,     // Transmit stream to SIE
   output logic                  tx_nak_o,
   output usb_io_pkg::usb_byte_t tx_data_o,
   input  logic                  tx_ready_i,
   input  logic                  out_full_i,
   output logic                  out_push_o,
   input  logic                  in0_empty_i,
   input  logic                  in1_empty_i,
   input  usb_io_pkg::usb_byte_t in0_data_i,
   input  usb_io_pkg::usb_byte_t in1_data_i,
   output logic                  in0_pop_o,
   output logic                  in1_pop_o
);

   typedef enum logic [1:0] {
      IDLE,
      SEND,
      NAK
   } state_t;

   state_t state_q;
   logic   ep_q;                        // Endpoint being served
   logic   run_q;                       // Low during and just after rst_i
   logic   req_hs;
   logic   tx_hs;
   logic   cur_empty;

   assign cur_empty = ep_q ? in1_empty_i : in0_empty_i;
   assign tx_data_o = ep_q ? in1_data_i : in0_data_i;  // FIFO head, holds until popped

   // OUT path runs independently of the IN state
   assign rx_ready_o = run_q && !out_full_i && !usb_reset_i;
   assign out_push_o = rx_valid_i && rx_ready_o;

   assign in_req_ready_o = run_q && (state_q == IDLE) && !usb_reset_i;
   assign req_hs         = in_req_valid_i && in_req_ready_o;

   // Stall if CPU has not refilled yet
   assign tx_valid_o = (state_q == SEND) && !cur_empty && !usb_reset_i;
   assign tx_hs      = tx_valid_o && tx_ready_i;
   assign tx_nak_o   = (state_q == NAK);  // Single cycle, NAK always returns to IDLE
   assign in0_pop_o  = tx_hs && !ep_q;
   assign in1_pop_o  = tx_hs && ep_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         run_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         ep_q    <= 1'b0;
      end else if (usb_reset_i) begin
         state_q <= IDLE;               // Abandon any transfer
      end else begin
         case (state_q)
            IDLE: begin
               if (req_hs) begin
                  ep_q <= in_ep_i;
                  // Empty endpoint answers NAK
                  state_q <= (in_ep_i ? in1_empty_i : in0_empty_i) ? NAK : SEND;
               end
            end
            SEND: begin
               if (tx_hs && tx_data_o.last) state_q <= IDLE;  // Packet done
            end
            NAK:     state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/se0_reset_timer.sv
// USB bus reset detector; D+/D- must already be synchronised to clk_i, THRESHOLD counts clock samples
`timescale 1ns/10ps
`default_nettype none
`include "usb_io_consts.svh"

module se0_reset_timer #(
   parameter int THRESHOLD = `SE0_CYCLES
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  usb_io_pkg::d_port_t d_i,
   output logic                usb_reset_o
);

   localparam int CW = $clog2(THRESHOLD + 1);
   localparam logic [CW-1:0] LIMIT = CW'(THRESHOLD);

   logic [CW-1:0] se0_cnt_q;            // Consecutive SE0 samples
   logic          se0;

   assign se0 = !d_i.dp && !d_i.dm;     // Both lines low

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         se0_cnt_q   <= '0;
         usb_reset_o <= 1'b0;
      end else if (!se0) begin
         se0_cnt_q   <= '0;             // Any J/K state restarts
         usb_reset_o <= 1'b0;           // Drops one cycle after line recovers
      end else begin
         if (se0_cnt_q != LIMIT) begin
            se0_cnt_q <= se0_cnt_q + 1'b1;  // Saturates at LIMIT
         end
         // This sample is number se0_cnt_q+1
         usb_reset_o <= (se0_cnt_q >= LIMIT - 1'b1);
      end
   end

endmodule

`default_nettype wire

// File: rtl/shared_bus.sv
// CPU I/O decoder; read data registered with one cycle latency, FIFO writes dropped when full
`timescale 1ns/10ps
`default_nettype none
`include "usb_io_consts.svh"

module shared_bus (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  usb_io_pkg::io_req_t   io_req_i,
   output logic [15:0]           io_din_o,    // Read data to CPU
   input  logic [9:0]            sw_i,
   output logic [15:0]           led_o,
   input  usb_io_pkg::ep_status_t status_i,
   input  usb_io_pkg::usb_rx_t   out_data_i,  // OUT FIFO head
   output logic                  out_pop_o,
   output usb_io_pkg::usb_byte_t in_data_o,   // Shared push data for IN FIFOs
   output logic                  in0_push_o,
   output logic                  in1_push_o
);

   logic        rd_ep0_out;
   logic        wr_led;
   logic [15:0] rd_mux;

   assign rd_ep0_out = io_req_i.rd && (io_req_i.addr == `IO_ADDR_EP0_OUT);
   assign wr_led     = io_req_i.wr && (io_req_i.addr == `IO_ADDR_LED);

   // Pop only a real entry
   assign out_pop_o = rd_ep0_out && !status_i.out_empty;

   assign in_data_o  = usb_io_pkg::usb_byte_t'(io_req_i.dout[8:0]);  // {data, last}
   assign in0_push_o = io_req_i.wr && (io_req_i.addr == `IO_ADDR_EP0_IN) && !status_i.in0_full;
   assign in1_push_o = io_req_i.wr && (io_req_i.addr == `IO_ADDR_EP1_IN) && !status_i.in1_full;

   always_comb begin
      case (io_req_i.addr)
         `IO_ADDR_SW:      rd_mux = {6'b0, sw_i};
         `IO_ADDR_LED:     rd_mux = led_o;
         `IO_ADDR_STATUS:  rd_mux = status_i;
         `IO_ADDR_EP0_OUT: rd_mux = status_i.out_empty ? 16'h0000 : {3'b0, out_data_i};
         default:          rd_mux = 16'h0000;  // Unmapped, also write-only IN ports
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (io_req_i.rd) begin
         io_din_o <= rd_mux;            // Holds until next read
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         led_o <= 16'h0000;
      end else if (wr_led) begin
         led_o <= io_req_i.dout;
      end
   end

endmodule

`default_nettype wire

// File: rtl/usb_io_consts.svh
// Shared sizes and I/O map; EP_DEPTH must be a power of two, SE0_CYCLES assumes a 24 MHz clock
`ifndef USB_IO_CONSTS_SVH
`define USB_IO_CONSTS_SVH

// Endpoint FIFO sizing
`define EP_DEPTH 8                      // Entries per endpoint, power of two

// USB bus reset detection
`define SE0_CYCLES 240000               // 10 ms of SE0 at 24 MHz

// Processor I/O register map
`define IO_ADDR_SW      16'h0000        // Slide switches, read only
`define IO_ADDR_LED     16'h0001        // LED register, read/write
`define IO_ADDR_STATUS  16'h0002        // Endpoint flags and bus reset
`define IO_ADDR_EP0_OUT 16'h0003        // Read pops OUT endpoint 0
`define IO_ADDR_EP0_IN  16'h0004        // Write pushes IN endpoint 0
`define IO_ADDR_EP1_IN  16'h0005        // Write pushes IN endpoint 1

`endif

// File: rtl/usb_io_pkg.sv
// Struct types for the USB/IO slice; field order fixes the bit layout seen by the processor
`default_nettype none

package usb_io_pkg;

   // Line sample, D- in the upper bit as on the board pins
   typedef struct packed {
      logic dm;                         // D- sample
      logic dp;                         // D+ sample
   } d_port_t;                          // Both low is SE0

   typedef struct packed {
      logic [15:0] addr;                // Register address
      logic [15:0] dout;                // Write data from CPU
      logic        rd;                  // One-cycle read strobe
      logic        wr;                  // One-cycle write strobe
   } io_req_t;

   typedef struct packed {
      logic [3:0] pid;                  // Token type, SETUP or OUT
      logic [7:0] data;                 // Payload byte
      logic       last;                 // Final byte of packet
   } usb_rx_t;

   typedef struct packed {
      logic [7:0] data;                 // Payload byte
      logic       last;                 // Final byte of packet
   } usb_byte_t;

   typedef struct packed {
      logic [8:0] reserved;             // Read as zero
      logic       usb_reset;            // Bus reset in progress
      logic       in1_full;
      logic       in1_empty;
      logic       in0_full;
      logic       in0_empty;
      logic       out_full;
      logic       out_empty;            // Bit 0
   } ep_status_t;

endpackage

`default_nettype wire

// File: rtl/usb_io_top.sv
// USB/IO slice top; rx/tx streams come from an external SIE, usb_d_i must be synchronous to clk_i
`timescale 1ns/10ps
`default_nettype none
`include "usb_io_consts.svh"

module usb_io_top #(
   parameter int SE0_THRESHOLD = `SE0_CYCLES
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  usb_io_pkg::io_req_t   io_req_i,
   output logic [15:0]           io_din_o,
   input  logic [9:0]            sw_i,
   output logic [15:0]           led_o,
   input  usb_io_pkg::d_port_t   usb_d_i,
   input  logic                  rx_valid_i,
   input  usb_io_pkg::usb_rx_t   rx_data_i,
   output logic                  rx_ready_o,
   input  logic                  in_req_valid_i,
   input  logic                  in_ep_i,
   output logic                  in_req_ready_o,
   output logic                  tx_valid_o,
   output usb_io_pkg::usb_byte_t tx_data_o,
   input  logic                  tx_ready_i,
   output logic                  tx_nak_o,
   output logic                  usb_reset_o
);

   usb_io_pkg::ep_status_t status;
   usb_io_pkg::usb_rx_t    out_data;    // OUT FIFO head to bus
   usb_io_pkg::usb_byte_t  in_wdata;    // Bus write data to IN FIFOs
   usb_io_pkg::usb_byte_t  in0_data;
   usb_io_pkg::usb_byte_t  in1_data;
   logic out_push, out_pop, out_empty, out_full;
   logic in0_push, in0_pop, in0_empty, in0_full;
   logic in1_push, in1_pop, in1_empty, in1_full;

   assign status.reserved  = '0;
   assign status.usb_reset = usb_reset_o;
   assign status.in1_full  = in1_full;
   assign status.in1_empty = in1_empty;
   assign status.in0_full  = in0_full;
   assign status.in0_empty = in0_empty;
   assign status.out_full  = out_full;
   assign status.out_empty = out_empty;

   se0_reset_timer #(.THRESHOLD(SE0_THRESHOLD)) se0_reset_timer_inst (
      .clk_i(clk_i), .rst_i(rst_i), .d_i(usb_d_i), .usb_reset_o(usb_reset_o));

   shared_bus shared_bus_inst (
      .clk_i(clk_i), .rst_i(rst_i), .io_req_i(io_req_i), .io_din_o(io_din_o),
      .sw_i(sw_i), .led_o(led_o), .status_i(status),
      .out_data_i(out_data), .out_pop_o(out_pop),
      .in_data_o(in_wdata), .in0_push_o(in0_push), .in1_push_o(in1_push));

   endpoint_sequencer endpoint_sequencer_inst (
      .clk_i(clk_i), .rst_i(rst_i), .usb_reset_i(usb_reset_o),
      .rx_valid_i(rx_valid_i), .rx_data_i(rx_data_i), .rx_ready_o(rx_ready_o),
      .in_req_valid_i(in_req_valid_i), .in_ep_i(in_ep_i), .in_req_ready_o(in_req_ready_o),
      .tx_valid_o(tx_valid_o), .tx_nak_o(tx_nak_o), .tx_data_o(tx_data_o),
      .tx_ready_i(tx_ready_i), .out_full_i(out_full), .out_push_o(out_push),
      .in0_empty_i(in0_empty), .in1_empty_i(in1_empty),
      .in0_data_i(in0_data), .in1_data_i(in1_data),
      .in0_pop_o(in0_pop), .in1_pop_o(in1_pop));

   // OUT endpoint 0, SIE writes, CPU reads
   endpoint_fifo #(.payload_t(usb_io_pkg::usb_rx_t)) ep0_out_fifo (
      .clk_i(clk_i), .rst_i(rst_i), .flush_i(usb_reset_o),
      .push_i(out_push), .pop_i(out_pop), .wr_data_i(rx_data_i),
      .rd_data_o(out_data), .empty_o(out_empty), .full_o(out_full));

   // IN endpoint 0, CPU writes, SIE reads
   endpoint_fifo #(.payload_t(usb_io_pkg::usb_byte_t)) ep0_in_fifo (
      .clk_i(clk_i), .rst_i(rst_i), .flush_i(usb_reset_o),
      .push_i(in0_push), .pop_i(in0_pop), .wr_data_i(in_wdata),
      .rd_data_o(in0_data), .empty_o(in0_empty), .full_o(in0_full));

   // IN endpoint 1
   endpoint_fifo #(.payload_t(usb_io_pkg::usb_byte_t)) ep1_in_fifo (
      .clk_i(clk_i), .rst_i(rst_i), .flush_i(usb_reset_o),
      .push_i(in1_push), .pop_i(in1_pop), .wr_data_i(in_wdata),
      .rd_data_o(in1_data), .empty_o(in1_empty), .full_o(in1_full));

endmodule

`default_nettype wire

// File: usb_io_top.f
+incdir+rtl
rtl/usb_io_pkg.sv
rtl/endpoint_fifo.sv
rtl/se0_reset_timer.sv
rtl/endpoint_sequencer.sv
rtl/shared_bus.sv
rtl/usb_io_top.sv
verification/usb_io_assert.sv
verification/usb_io_tb.sv

// File: verification/usb_io_assert.sv
// Bound handshake checks for usb_io_top; expects synchronous active-high rst_i held at start of run
`timescale 1ns/10ps
`default_nettype none

module usb_io_assert (
   input logic                  clk_i,
   input logic                  rst_i,
   input logic                  usb_reset_i,
   input logic                  rx_ready_i,
   input logic                  out_full_i,      // OUT FIFO full flag
   input logic                  in_req_ready_i,
   input logic                  tx_valid_i,
   input logic                  tx_ready_i,
   input logic                  tx_nak_i,
   input usb_io_pkg::usb_byte_t tx_data_i,
   input logic [15:0]           led_i
);

   int fail_count = 0;                          // Failures so far, polled by testbench

   tx_hold: assert property (@(posedge clk_i) disable iff (rst_i || usb_reset_i)
      tx_valid_i && !tx_ready_i |=> $stable(tx_data_i))
      else begin
         $error("tx_data_o changed while the entry was stalled");
         fail_count++;
      end

   rx_full: assert property (@(posedge clk_i) disable iff (rst_i)
      !(rx_ready_i && out_full_i))
      else begin
         $error("rx_ready_o high with the OUT FIFO full");
         fail_count++;
      end

   nak_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      tx_nak_i |=> !tx_nak_i)
      else begin
         $error("tx_nak_o held for more than one cycle");
         fail_count++;
      end

   // All controls quiet on the cycle after a reset cycle
   reset_quiet: assert property (@(posedge clk_i)
      rst_i |=> !rx_ready_i && !in_req_ready_i && !tx_valid_i && !tx_nak_i
                && !usb_reset_i && (led_i == 16'h0000))
      else begin
         $error("control output not low after reset");
         fail_count++;
      end

endmodule

bind usb_io_top usb_io_assert usb_io_assert_inst (
   .clk_i(clk_i), .rst_i(rst_i), .usb_reset_i(usb_reset_o), .rx_ready_i(rx_ready_o),
   .out_full_i(out_full), .in_req_ready_i(in_req_ready_o), .tx_valid_i(tx_valid_o),
   .tx_ready_i(tx_ready_i), .tx_nak_i(tx_nak_o), .tx_data_i(tx_data_o), .led_i(led_o));

`default_nettype wire

// File: verification/usb_io_tb.sv
// Testbench for usb_io_top with SE0 threshold cut to 64; plays the CPU bus and the SIE streams
`timescale 1ns/10ps
`default_nettype none
`include "usb_io_consts.svh"

module usb_io_tb;

   localparam int         TIMEOUT   = 400;   // Cycles allowed per wait loop
   localparam int         SE0_LEN   = 64;    // Short bus reset threshold
   localparam logic [3:0] PID_OUT   = 4'h1;
   localparam logic [3:0] PID_SETUP = 4'hD;

   logic                  clk;
   logic                  rst;
   usb_io_pkg::io_req_t   io_req;
   logic [15:0]           io_din;
   logic [9:0]            sw;
   logic [15:0]           led;
   usb_io_pkg::d_port_t   usb_d;
   logic                  rx_valid;
   usb_io_pkg::usb_rx_t   rx_data;
   logic                  rx_ready;
   logic                  in_req_valid;
   logic                  in_ep;
   logic                  in_req_ready;
   logic                  tx_valid;
   usb_io_pkg::usb_byte_t tx_data;
   logic                  tx_ready;
   logic                  tx_nak;
   logic                  usb_reset;

   usb_io_pkg::usb_rx_t   out_q[$];        // Expected OUT FIFO contents
   usb_io_pkg::usb_byte_t in0_q[$];        // Expected IN FIFO contents
   usb_io_pkg::usb_byte_t in1_q[$];

   usb_io_top #(.SE0_THRESHOLD(SE0_LEN)) usb_io_top_inst (
      .clk_i(clk), .rst_i(rst), .io_req_i(io_req), .io_din_o(io_din),
      .sw_i(sw), .led_o(led), .usb_d_i(usb_d),
      .rx_valid_i(rx_valid), .rx_data_i(rx_data), .rx_ready_o(rx_ready),
      .in_req_valid_i(in_req_valid), .in_ep_i(in_ep), .in_req_ready_o(in_req_ready),
      .tx_valid_o(tx_valid), .tx_data_o(tx_data), .tx_ready_i(tx_ready),
      .tx_nak_o(tx_nak), .usb_reset_o(usb_reset));

   always #10 clk = ~clk;                  // 20 ns period

   task automatic stop_fail();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp) else begin
         $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
         stop_fail();
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout while waiting for %s", what);
      stop_fail();
   endtask

   // Stop on the first bound assertion failure
   always @(negedge clk) begin
      if (usb_io_top_inst.usb_io_assert_inst.fail_count != 0) begin
         $display("A concurrent assertion on usb_io_top failed");
         stop_fail();
      end
   end

   task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
      @(negedge clk);
      io_req = '{addr: addr, dout: data, rd: 1'b0, wr: 1'b1};
      @(negedge clk);
      io_req.wr = 1'b0;                     // One-cycle strobe
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
      @(negedge clk);
      io_req = '{addr: addr, dout: 16'h0000, rd: 1'b1, wr: 1'b0};
      @(negedge clk);
      io_req.rd = 1'b0;
      data = io_din;                        // Read data registered one cycle after rd
   endtask

   task automatic read_out_check();
      logic [15:0] d;
      logic [15:0] exp;
      exp = 16'h0000;                       // Empty FIFO reads zero
      if (out_q.size() != 0) exp = {3'b000, out_q.pop_front()};
      bus_read(`IO_ADDR_EP0_OUT, d);
      check_eq("io_din_o", exp, d);
   endtask

   function automatic usb_io_pkg::usb_rx_t rand_rx(input logic last);
      usb_io_pkg::usb_rx_t e;
      e.pid  = $urandom_range(1) ? PID_SETUP : PID_OUT;
      e.data = 8'($urandom);
      e.last = last;
      return e;
   endfunction

   task automatic offer_rx(input usb_io_pkg::usb_rx_t e);
      @(negedge clk);
      rx_valid = 1'b1;
      rx_data  = e;
   endtask

   task automatic finish_rx();
      int n;
      n = 0;
      #1;
      while (!rx_ready) begin
         n = n + 1;
         if (n > TIMEOUT) timeout_fail("rx_ready_o");
         @(negedge clk);
         #1;
      end
      out_q.push_back(rx_data);             // Taken on the next rising edge
      @(negedge clk);
      rx_valid = 1'b0;
   endtask

   task automatic send_packet(input int len);
      for (int i = 0; i < len; i++) begin
         offer_rx(rand_rx(i == len - 1));
         finish_rx();
      end
   endtask

   task automatic push_in(input logic ep, input int len);
      usb_io_pkg::usb_byte_t b;
      for (int i = 0; i < len; i++) begin
         b.data = 8'($urandom);
         b.last = (i == len - 1);           // Packet end marker
         if (ep) begin
            in1_q.push_back(b);
         end else begin
            in0_q.push_back(b);
         end
         bus_write(ep ? `IO_ADDR_EP1_IN : `IO_ADDR_EP0_IN, {7'b0, b});
      end
   endtask

   task automatic request_in(input logic ep);
      int n;
      n = 0;
      @(negedge clk);
      in_req_valid = 1'b1;
      in_ep        = ep;
      #1;
      while (!in_req_ready) begin
         n = n + 1;
         if (n > TIMEOUT) timeout_fail("in_req_ready_o");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      in_req_valid = 1'b0;                  // Request taken on last rising edge
   endtask

   task automatic collect_packet(input logic ep);
      usb_io_pkg::usb_byte_t exp;
      logic                  done;
      int                    n;
      done = 1'b0;
      n    = 0;
      request_in(ep);
      check_eq("tx_valid_o", 16'd1, {15'b0, tx_valid});  // One cycle after request
      check_eq("in_req_ready_o", 16'd0, {15'b0, in_req_ready});  // Busy sending
      while (!done) begin
         tx_ready = 1'($urandom);           // Random back-pressure
         #1;
         if (tx_valid && tx_ready) begin
            exp = ep ? in1_q.pop_front() : in0_q.pop_front();
            check_eq("tx_data_o", {7'b0, exp}, {7'b0, tx_data});
            done = exp.last;
         end
         n = n + 1;
         if (n > TIMEOUT) timeout_fail("last entry on tx_data_o");
         @(negedge clk);
      end
      tx_ready = 1'b0;
      #1;
      check_eq("tx_valid_o", 16'd0, {15'b0, tx_valid});  // Nothing past last
      check_eq("in_req_ready_o", 16'd1, {15'b0, in_req_ready});  // Back in IDLE
   endtask

   initial begin
      logic [15:0]            d;
      usb_io_pkg::ep_status_t st;
      int                     n;
      void'($urandom(32'h228e));
      clk          = 1'b0;
      rst          = 1'b1;
      io_req       = '0;
      sw           = 10'($urandom);
      usb_d        = 2'b01;                 // J state with D+ high
      rx_valid     = 1'b0;
      rx_data      = '0;
      in_req_valid = 1'b0;
      in_ep        = 1'b0;
      tx_ready     = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      d = 16'($urandom);                    // LED write then switch read
      bus_write(`IO_ADDR_LED, d);
      check_eq("led_o", d, led);
      bus_read(`IO_ADDR_SW, d);
      check_eq("io_din_o", {6'b0, sw}, d);

      repeat (4) begin                      // OUT packets read back in order
         send_packet($urandom_range(1, 4));
         repeat (out_q.size()) read_out_check();
      end
      read_out_check();

      push_in(1'b1, $urandom_range(1, 4));  // Two packets queued on EP1
      push_in(1'b1, $urandom_range(1, 4));
      push_in(1'b0, $urandom_range(1, 4));
      collect_packet(1'b1);
      collect_packet(1'b0);
      collect_packet(1'b1);

      request_in(1'b0);                     // Drained EP0 answers NAK
      check_eq("tx_nak_o", 16'd1, {15'b0, tx_nak});
      check_eq("tx_valid_o", 16'd0, {15'b0, tx_valid});
      @(negedge clk);
      check_eq("tx_nak_o", 16'd0, {15'b0, tx_nak});

      repeat (8) begin                      // Fill OUT FIFO
         offer_rx(rand_rx(1'b1));
         finish_rx();
      end
      offer_rx(rand_rx(1'b1));
      repeat (4) begin
         @(negedge clk);
         #1;
         check_eq("rx_ready_o", 16'd0, {15'b0, rx_ready});
      end
      read_out_check();                     // Frees one slot
      finish_rx();
      repeat (9) read_out_check();

      send_packet(1);                       // Data to be flushed
      push_in(1'b0, 2);
      @(negedge clk);
      usb_d = 2'b00;                        // SE0
      n = 0;
      while (!usb_reset) begin
         n = n + 1;
         if (n > TIMEOUT) timeout_fail("usb_reset_o to rise");
         @(negedge clk);
      end
      check_eq("usb_reset_o rise delay", 16'(SE0_LEN), 16'(n));  // SE0 samples seen
      bus_read(`IO_ADDR_STATUS, d);
      st           = '0;
      st.usb_reset = 1'b1;
      st.out_empty = 1'b1;
      st.in0_empty = 1'b1;
      st.in1_empty = 1'b1;
      check_eq("io_din_o", st, d);
      check_eq("rx_ready_o", 16'd0, {15'b0, rx_ready});
      @(negedge clk);
      usb_d = 2'b01;
      n = 0;
      while (usb_reset) begin
         n = n + 1;
         if (n > TIMEOUT) timeout_fail("usb_reset_o to fall");
         @(negedge clk);
      end
      check_eq("usb_reset_o fall delay", 16'd1, 16'(n));  // One J sample ends it
      out_q.delete();                       // Flushed by bus reset
      in0_q.delete();
      send_packet(2);
      repeat (2) read_out_check();
      push_in(1'b0, 3);
      collect_packet(1'b0);

      repeat (4) @(negedge clk);
      if (usb_io_top_inst.usb_io_assert_inst.fail_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("A concurrent assertion on usb_io_top failed");
         stop_fail();
      end
   end

endmodule

`default_nettype wire
